//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_toplevel -f toplevel.f
	./obj_dir/Vtb_toplevel | tee /dev/stderr | grep -F -q '*** PASSED ***'

lint:
	verilator --lint-only --timing -Wall --top-module toplevel -f toplevel.f

clean:
	rm -rf obj_dir

//--- common/data_bus_if.sv
/*
 * Data memory access bus between core and data memory,
 * with core and mem modports
 */
`timescale 1ns/100ps
`default_nettype none

interface data_bus_if;

  rv_pkg::word_t    address;
  rv_pkg::word_t    write_data;
  rv_pkg::byte_en_t byte_enable;
  logic             read_enable;
  logic             write_enable;
  rv_pkg::word_t    read_data;

  modport core (
    output address, write_data, byte_enable, read_enable, write_enable,
    input  read_data
  );

  modport mem (
    input  address, write_data, byte_enable, read_enable, write_enable,
    output read_data
  );

endinterface

`default_nettype wire

//--- common/rv_pkg.sv
/*
 * RV32I subset package: word, register, byte-enable and ALU types,
 * ALU operation codes, opcode, funct3 and funct7 constants
 */
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // ALU operations
  localparam alu_op_t ALU_ADD    = 3'd0;
  localparam alu_op_t ALU_SUB    = 3'd1;
  localparam alu_op_t ALU_AND    = 3'd2;
  localparam alu_op_t ALU_OR     = 3'd3;
  localparam alu_op_t ALU_XOR    = 3'd4;
  localparam alu_op_t ALU_SLT    = 3'd5;
  localparam alu_op_t ALU_PASS_B = 3'd6;

  // --------------------------------------------------
  // Opcodes, one per format
  // --------------------------------------------------
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;

  // Arithmetic and logic funct3
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // Memory and branch funct3
  localparam funct3_t F3_LW      = 3'b010;
  localparam funct3_t F3_SB      = 3'b000;
  localparam funct3_t F3_SW      = 3'b010;
  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;

  // funct7 for register-register ops
  localparam funct7_t F7_BASE    = 7'b0000000;
  localparam funct7_t F7_SUB     = 7'b0100000;

endpackage

`default_nettype wire

//--- core/alu_execute.sv
/*
 * Execute stage: ALU on register or immediate operand,
 * branch compare, next PC and link value
 */
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
  input  wire rv_pkg::word_t   i_pc,
  input  wire rv_pkg::word_t   i_rs1_value,
  input  wire rv_pkg::word_t   i_rs2_value,
  input  wire rv_pkg::word_t   i_imm,
  input  wire rv_pkg::alu_op_t i_alu_op,
  input  wire logic            i_use_imm,
  input  wire logic            i_is_branch,
  input  wire logic            i_branch_ne,
  input  wire logic            i_is_jal,
  output rv_pkg::word_t        o_alu_result,
  output rv_pkg::word_t        o_next_pc,
  output rv_pkg::word_t        o_link
);

  rv_pkg::word_t operand_b;
  rv_pkg::word_t pc_plus_4;
  logic          operands_equal;
  logic          branch_taken;

  assign operand_b = i_use_imm ? i_imm : i_rs2_value;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (i_alu_op)
      rv_pkg::ALU_ADD:    o_alu_result = i_rs1_value + operand_b;
      rv_pkg::ALU_SUB:    o_alu_result = i_rs1_value - operand_b;
      rv_pkg::ALU_AND:    o_alu_result = i_rs1_value & operand_b;
      rv_pkg::ALU_OR:     o_alu_result = i_rs1_value | operand_b;
      rv_pkg::ALU_XOR:    o_alu_result = i_rs1_value ^ operand_b;
      rv_pkg::ALU_SLT:
        o_alu_result = {31'b0, $signed(i_rs1_value) < $signed(operand_b)};
      rv_pkg::ALU_PASS_B: o_alu_result = operand_b;
      default:            o_alu_result = '0;
    endcase
  end

  // --------------------------------------------------
  // Branch decision and next PC
  // --------------------------------------------------
  // Branches always compare the two registers
  assign operands_equal = (i_rs1_value == i_rs2_value);
  assign branch_taken   = i_is_branch && (operands_equal ^ i_branch_ne);

  assign pc_plus_4 = i_pc + 32'd4;
  assign o_next_pc = (branch_taken || i_is_jal) ? i_pc + i_imm : pc_plus_4;
  assign o_link    = pc_plus_4;

endmodule

`default_nettype wire

//--- core/instr_decoder.sv
/*
 * Instruction decoder: register fields, immediate by format,
 * ALU operation and control flags, illegal encoding check
 */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  wire logic              i_clock,
  input  wire logic              i_reset,
  input  wire rv_pkg::word_t     i_inst,
  output rv_pkg::reg_addr_t      o_rs1,
  output rv_pkg::reg_addr_t      o_rs2,
  output rv_pkg::reg_addr_t      o_rd,
  output rv_pkg::word_t          o_imm,
  output rv_pkg::alu_op_t        o_alu_op,
  output logic                   o_use_imm,
  output logic                   o_reg_write,
  output logic                   o_is_load,
  output logic                   o_is_store,
  output logic                   o_store_byte,
  output logic                   o_is_branch,
  output logic                   o_branch_ne,
  output logic                   o_is_jal,
  output logic                   o_illegal
);

  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  rv_pkg::funct7_t funct7;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rd   = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  // Immediates, all sign extended from bit 31 except U
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // --------------------------------------------------
  // Control decode
  // --------------------------------------------------
  always_comb begin
    o_imm        = imm_i;
    o_alu_op     = rv_pkg::ALU_ADD;
    o_use_imm    = 1'b0;
    o_reg_write  = 1'b0;
    o_is_load    = 1'b0;
    o_is_store   = 1'b0;
    o_store_byte = 1'b0;
    o_is_branch  = 1'b0;
    o_branch_ne  = 1'b0;
    o_is_jal     = 1'b0;
    o_illegal    = 1'b0;

    case (opcode)
      rv_pkg::OPC_LUI: begin
        o_imm       = imm_u;
        o_alu_op    = rv_pkg::ALU_PASS_B;
        o_use_imm   = 1'b1;
        o_reg_write = 1'b1;
      end
      rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
        o_use_imm   = (opcode == rv_pkg::OPC_OP_IMM);
        o_reg_write = 1'b1;
        case (funct3)
          rv_pkg::F3_ADD_SUB: o_alu_op = rv_pkg::ALU_ADD;
          rv_pkg::F3_SLT:     o_alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_XOR:     o_alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_OR:      o_alu_op = rv_pkg::ALU_OR;
          rv_pkg::F3_AND:     o_alu_op = rv_pkg::ALU_AND;
          default:            o_illegal = 1'b1;
        endcase
        // Only ADD may carry the SUB funct7, and only as a register op
        if (opcode == rv_pkg::OPC_OP) begin
          if (funct7 == rv_pkg::F7_SUB && funct3 == rv_pkg::F3_ADD_SUB)
            o_alu_op = rv_pkg::ALU_SUB;
          else if (funct7 != rv_pkg::F7_BASE)
            o_illegal = 1'b1;
        end
      end
      rv_pkg::OPC_LOAD: begin
        o_use_imm   = 1'b1;
        o_reg_write = 1'b1;
        o_is_load   = 1'b1;
        o_illegal   = (funct3 != rv_pkg::F3_LW);
      end
      rv_pkg::OPC_STORE: begin
        o_imm        = imm_s;
        o_use_imm    = 1'b1;
        o_is_store   = 1'b1;
        o_store_byte = (funct3 == rv_pkg::F3_SB);
        o_illegal    = (funct3 != rv_pkg::F3_SB) && (funct3 != rv_pkg::F3_SW);
      end
      rv_pkg::OPC_BRANCH: begin
        o_imm       = imm_b;
        o_is_branch = 1'b1;
        o_branch_ne = (funct3 == rv_pkg::F3_BNE);
        o_illegal   = (funct3 != rv_pkg::F3_BEQ) && (funct3 != rv_pkg::F3_BNE);
      end
      rv_pkg::OPC_JAL: begin
        o_imm       = imm_j;
        o_reg_write = 1'b1;
        o_is_jal    = 1'b1;
      end
      default: o_illegal = 1'b1;
    endcase
  end

  // Program in text memory holds supported encodings only
  a_no_illegal: assert property (@(posedge i_clock) disable iff (i_reset) !o_illegal);

endmodule

`default_nettype wire

//--- core/result_select.sv
/*
 * Write-back value selection between load data,
 * JAL link address and ALU result
 */
`timescale 1ns/100ps
`default_nettype none

module result_select (
  input  wire rv_pkg::word_t i_alu_result,
  input  wire rv_pkg::word_t i_load_data,
  input  wire rv_pkg::word_t i_link,
  input  wire logic          i_is_load,
  input  wire logic          i_is_jal,
  output rv_pkg::word_t      o_result
);

  // Only LW is supported, so the bus word is the loaded value as is
  rv_pkg::word_t load_value;

  assign load_value = i_load_data;

  // Load wins, then link, then ALU
  always_comb begin
    if (i_is_load)
      o_result = load_value;
    else if (i_is_jal)
      o_result = i_link;
    else
      o_result = i_alu_result;
  end

endmodule

`default_nettype wire

//--- core/riscv_core.sv
/*
 * Single-cycle RV32I subset core with PC, register file,
 * decode/execute/result instances and data bus drive
 */
`timescale 1ns/100ps
`default_nettype none

module riscv_core #(
  parameter int DATA_ADDR_BITS = 6
) (
  input  wire logic          i_clock,
  input  wire logic          i_reset,
  input  wire rv_pkg::word_t i_inst,
  output rv_pkg::word_t      o_pc,
  data_bus_if.core           bus
);

  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm;
  rv_pkg::alu_op_t   alu_op;
  logic              use_imm;
  logic              reg_write;
  logic              is_load;
  logic              is_store;
  logic              store_byte;
  logic              is_branch;
  logic              branch_ne;
  logic              is_jal;
  logic              illegal;
  rv_pkg::word_t     rs1_value;
  rv_pkg::word_t     rs2_value;
  rv_pkg::word_t     alu_result;
  rv_pkg::word_t     next_pc;
  rv_pkg::word_t     link;
  rv_pkg::word_t     result;
  rv_pkg::word_t     regs [32];

  instr_decoder decoder (
    .i_clock(i_clock), .i_reset(i_reset), .i_inst(i_inst),
    .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm), .o_alu_op(alu_op),
    .o_use_imm(use_imm), .o_reg_write(reg_write), .o_is_load(is_load),
    .o_is_store(is_store), .o_store_byte(store_byte), .o_is_branch(is_branch),
    .o_branch_ne(branch_ne), .o_is_jal(is_jal), .o_illegal(illegal)
  );

  alu_execute execute (
    .i_pc(o_pc), .i_rs1_value(rs1_value), .i_rs2_value(rs2_value), .i_imm(imm),
    .i_alu_op(alu_op), .i_use_imm(use_imm), .i_is_branch(is_branch),
    .i_branch_ne(branch_ne), .i_is_jal(is_jal),
    .o_alu_result(alu_result), .o_next_pc(next_pc), .o_link(link)
  );

  result_select result_sel (
    .i_alu_result(alu_result), .i_load_data(bus.read_data), .i_link(link),
    .i_is_load(is_load), .i_is_jal(is_jal), .o_result(result)
  );

  // x0 reads as zero
  assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

  // --------------------------------------------------
  // Data bus
  // --------------------------------------------------
  // Fetched word is not valid while the program is still loading
  assign bus.read_enable  = is_load && !i_reset && !illegal;
  assign bus.write_enable = is_store && !i_reset && !illegal;
  assign bus.address      = alu_result;
  assign bus.write_data   = store_byte ? {4{rs2_value[7:0]}} : rs2_value;
  assign bus.byte_enable  = !is_store  ? 4'b0000 :
                            store_byte ? 4'b0001 << alu_result[1:0] : 4'b1111;

  // PC and register file
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_pc <= '0;
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else begin
      o_pc <= next_pc;
      if (reg_write && rd != '0)
        regs[rd] <= result;
    end
  end

  a_pc_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
    o_pc[1:0] == 2'b00);
  a_rw_exclusive: assert property (@(posedge i_clock)
    !(bus.read_enable && bus.write_enable));
  a_access_in_range: assert property (@(posedge i_clock) disable iff (i_reset)
    (bus.read_enable || bus.write_enable) |-> bus.address[31:DATA_ADDR_BITS+2] == '0);

endmodule

`default_nettype wire

//--- src/data_memory.sv
/*
 * Data memory, byte-lane synchronous write,
 * combinational read, cleared while in reset
 */
`timescale 1ns/100ps
`default_nettype none

module data_memory #(
  parameter int DATA_ADDR_BITS = 6
) (
  input  wire logic i_clock,
  input  wire logic i_reset,
  data_bus_if.mem   bus
);

  localparam int WORDS = 2 ** DATA_ADDR_BITS;

  rv_pkg::word_t               mem [WORDS];
  logic [DATA_ADDR_BITS-1:0]   word_index;

  // Byte address to word index, wrapping
  assign word_index    = bus.address[DATA_ADDR_BITS+1:2];
  assign bus.read_data = mem[word_index];

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < WORDS; i++)
        mem[i] <= '0;
    end else if (bus.write_enable) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus.byte_enable[lane])
          mem[word_index][lane*8 +: 8] <= bus.write_data[lane*8 +: 8];
      end
    end
  end

  // Core keeps its stores off the bus until reset is released
  a_no_write_in_reset: assert property (@(posedge i_clock)
    i_reset |-> !bus.write_enable);

endmodule

`default_nettype wire

//--- src/text_memory.sv
/*
 * Instruction memory, combinational word read,
 * synchronous load port for program placement
 */
`timescale 1ns/100ps
`default_nettype none

module text_memory #(
  parameter int TEXT_ADDR_BITS = 6
) (
  input  wire logic          i_clock,
  input  wire rv_pkg::word_t i_address,
  output rv_pkg::word_t      o_read_data,
  input  wire logic          i_load_enable,
  input  wire rv_pkg::word_t i_load_address,
  input  wire rv_pkg::word_t i_load_data
);

  localparam int WORDS = 2 ** TEXT_ADDR_BITS;

  rv_pkg::word_t mem [WORDS];

  // Fetch uses the byte address; upper bits wrap
  assign o_read_data = mem[i_address[TEXT_ADDR_BITS+1:2]];

  // Load port takes a word index
  always_ff @(posedge i_clock) begin
    if (i_load_enable)
      mem[i_load_address[TEXT_ADDR_BITS-1:0]] <= i_load_data;
  end

endmodule

`default_nettype wire

//--- src/toplevel.sv
/*
 * Top level: core, text memory and data memory on one data bus,
 * with the program load port and observation outputs
 */
`timescale 1ns/100ps
`default_nettype none

module toplevel #(
  parameter int TEXT_ADDR_BITS = 6,
  parameter int DATA_ADDR_BITS = 6
) (
  input  wire logic             i_clock,
  input  wire logic             i_reset,
  input  wire logic             i_load_enable,
  input  wire rv_pkg::word_t    i_load_address,
  input  wire rv_pkg::word_t    i_load_data,
  output rv_pkg::word_t         o_pc,
  output rv_pkg::word_t         o_inst,
  output rv_pkg::word_t         o_bus_address,
  output rv_pkg::word_t         o_bus_write_data,
  output rv_pkg::word_t         o_bus_read_data,
  output rv_pkg::byte_en_t      o_bus_byte_enable,
  output logic                  o_bus_read_enable,
  output logic                  o_bus_write_enable
);

  data_bus_if data_bus ();

  // --------------------------------------------------
  // Core and memories
  // --------------------------------------------------
  riscv_core #(
    .DATA_ADDR_BITS(DATA_ADDR_BITS)
  ) core (
    .i_clock(i_clock),
    .i_reset(i_reset),
    .i_inst(o_inst),
    .o_pc(o_pc),
    .bus(data_bus.core)
  );

  text_memory #(
    .TEXT_ADDR_BITS(TEXT_ADDR_BITS)
  ) text_mem (
    .i_clock(i_clock),
    .i_address(o_pc),
    .o_read_data(o_inst),
    .i_load_enable(i_load_enable),
    .i_load_address(i_load_address),
    .i_load_data(i_load_data)
  );

  data_memory #(
    .DATA_ADDR_BITS(DATA_ADDR_BITS)
  ) data_mem (
    .i_clock(i_clock),
    .i_reset(i_reset),
    .bus(data_bus.mem)
  );

  // Observation of the data bus
  assign o_bus_address      = data_bus.address;
  assign o_bus_write_data   = data_bus.write_data;
  assign o_bus_read_data    = data_bus.read_data;
  assign o_bus_byte_enable  = data_bus.byte_enable;
  assign o_bus_read_enable  = data_bus.read_enable;
  assign o_bus_write_enable = data_bus.write_enable;

endmodule

`default_nettype wire

//--- test/rv_model.svh
/*
 * Random program generator, instruction encoders and
 * reference model of the RV32I subset machine state
 */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

rv_pkg::word_t    prog [PROG_WORDS];
rv_pkg::word_t    m_regs [32];
rv_pkg::word_t    m_mem [DATA_WORDS];
rv_pkg::word_t    m_pc;
logic             at_loop;
logic             exp_we;
logic             exp_re;
rv_pkg::word_t    exp_addr;
rv_pkg::word_t    exp_wdata;
rv_pkg::word_t    exp_rdata;
rv_pkg::byte_en_t exp_be;

function automatic rv_pkg::word_t rand_word();
  return $random(seed);
endfunction

function automatic int unsigned rand_below(input int unsigned n);
  return {$random(seed)} % n;
endfunction

function automatic logic [2:0] pick_f3();
  case (rand_below(5))
    0:       return rv_pkg::F3_ADD_SUB;
    1:       return rv_pkg::F3_SLT;
    2:       return rv_pkg::F3_XOR;
    3:       return rv_pkg::F3_OR;
    default: return rv_pkg::F3_AND;
  endcase
endfunction

// --------------------------------------------------
// Instruction encoders
// --------------------------------------------------
function automatic rv_pkg::word_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, rv_pkg::OPC_LUI};
endfunction

function automatic rv_pkg::word_t imm_op_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
endfunction

function automatic rv_pkg::word_t reg_op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

// Loads and stores always use x0 as base
function automatic rv_pkg::word_t load_word(input logic [11:0] off, input logic [4:0] rd);
  return {off, 5'd0, rv_pkg::F3_LW, rd, rv_pkg::OPC_LOAD};
endfunction

function automatic rv_pkg::word_t store_word(input logic [11:0] off, input logic [4:0] rs2,
                                             input logic [2:0] f3);
  return {off[11:5], rs2, 5'd0, f3, off[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic rv_pkg::word_t branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic rv_pkg::word_t jal_word(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
endfunction

// --------------------------------------------------
// Program generation
// --------------------------------------------------
task automatic build_program();
  rv_pkg::word_t r;
  logic [2:0]    f3;
  logic [4:0]    rd;
  logic [4:0]    rs1;
  logic [4:0]    rs2;
  int unsigned   alu_run;
  int unsigned   limit;
  int unsigned   span;
  alu_run = 0;
  for (int i = 0; i < PROG_WORDS - 1; i++) begin
    r     = rand_word();
    f3    = pick_f3();
    rd    = 5'(rand_below(8));
    rs1   = 5'(rand_below(8));
    rs2   = 5'(rand_below(8));
    limit = (PROG_WORDS - 1 - i > 6) ? 6 : PROG_WORDS - 1 - i;
    span  = 1 + rand_below(limit);
    // Make recent ALU results visible on the bus
    if (alu_run >= 3) begin
      prog[i] = store_word(12'(rand_below(DATA_WORDS) * 4), rs2, rv_pkg::F3_SW);
      alu_run = 0;
    end else begin
      case (rand_below(8))
        0: prog[i] = lui_word(r[19:0], rd);
        1, 2: prog[i] = imm_op_word(r[11:0], rs1, f3, rd);
        3: prog[i] = reg_op_word((f3 == rv_pkg::F3_ADD_SUB && r[0]) ? rv_pkg::F7_SUB :
                                 rv_pkg::F7_BASE, rs2, rs1, f3, rd);
        4: prog[i] = load_word(12'(rand_below(DATA_WORDS) * 4), rd);
        5: prog[i] = store_word(12'(rand_below(DATA_WORDS * 4)), rs2, rv_pkg::F3_SB);
        6: prog[i] = branch_word(13'(span * 4), rs2, rs1,
                                 r[0] ? rv_pkg::F3_BNE : rv_pkg::F3_BEQ);
        default: prog[i] = jal_word(21'(span * 4), rd);
      endcase
      if (prog[i][6:0] == rv_pkg::OPC_LUI || prog[i][6:0] == rv_pkg::OPC_OP_IMM ||
          prog[i][6:0] == rv_pkg::OPC_OP)
        alu_run++;
    end
  end
  // Final jump to itself
  prog[PROG_WORDS-1] = jal_word(21'd0, 5'd0);
endtask

// --------------------------------------------------
// Reference model
// --------------------------------------------------
task automatic reset_model();
  m_pc    = '0;
  at_loop = 1'b0;
  for (int i = 0; i < 32; i++)
    m_regs[i] = '0;
  for (int i = 0; i < DATA_WORDS; i++)
    m_mem[i] = '0;
endtask

function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic sub,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
  case (f3)
    rv_pkg::F3_ADD_SUB: return sub ? a - b : a + b;
    rv_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    rv_pkg::F3_XOR:     return a ^ b;
    rv_pkg::F3_OR:      return a | b;
    default:            return a & b;
  endcase
endfunction

// Executes the instruction at m_pc and sets the expected bus values
task automatic execute_model();
  rv_pkg::word_t         w;
  rv_pkg::word_t         a;
  rv_pkg::word_t         b;
  rv_pkg::word_t         res;
  rv_pkg::word_t         next;
  logic [DATA_BITS-1:0]  idx;
  logic                  wr;
  w    = prog[m_pc[TEXT_BITS+1:2]];
  a    = m_regs[w[19:15]];
  b    = m_regs[w[24:20]];
  next = m_pc + 32'd4;
  res  = '0;
  wr   = 1'b0;
  exp_we    = 1'b0;
  exp_re    = 1'b0;
  exp_addr  = '0;
  exp_wdata = '0;
  exp_rdata = '0;
  exp_be    = '0;
  case (w[6:0])
    rv_pkg::OPC_LUI: begin
      res = {w[31:12], 12'b0};
      wr  = 1'b1;
    end
    rv_pkg::OPC_OP_IMM: begin
      res = alu_model(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
      wr  = 1'b1;
    end
    rv_pkg::OPC_OP: begin
      res = alu_model(w[14:12], w[30], a, b);
      wr  = 1'b1;
    end
    rv_pkg::OPC_LOAD: begin
      exp_re    = 1'b1;
      exp_addr  = a + {{20{w[31]}}, w[31:20]};
      exp_rdata = m_mem[exp_addr[DATA_BITS+1:2]];
      res       = exp_rdata;
      wr        = 1'b1;
    end
    rv_pkg::OPC_STORE: begin
      exp_we   = 1'b1;
      exp_addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
      if (w[14:12] == rv_pkg::F3_SB) begin
        exp_be    = 4'b0001 << exp_addr[1:0];
        exp_wdata = {4{b[7:0]}};
      end else begin
        exp_be    = 4'b1111;
        exp_wdata = b;
      end
      idx = exp_addr[DATA_BITS+1:2];
      for (int lane = 0; lane < 4; lane++)
        if (exp_be[lane])
          m_mem[idx][lane*8 +: 8] = exp_wdata[lane*8 +: 8];
    end
    rv_pkg::OPC_BRANCH: begin
      if ((a == b) != (w[14:12] == rv_pkg::F3_BNE))
        next = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    end
    default: begin
      res  = m_pc + 32'd4;
      wr   = 1'b1;
      next = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    end
  endcase
  if (wr && w[11:7] != 5'd0)
    m_regs[w[11:7]] = res;
  at_loop = (next == m_pc);
  m_pc    = next;
endtask

`endif

//--- test/tb_toplevel.sv
/*
 * Testbench for the single-cycle core: clock, reset,
 * random program load, per-cycle compare with the model
 */
`timescale 1ns/100ps
`default_nettype none

module tb_toplevel;

  localparam int TEXT_BITS  = 6;
  localparam int DATA_BITS  = 6;
  localparam int PROG_WORDS = 2 ** TEXT_BITS;
  localparam int DATA_WORDS = 2 ** DATA_BITS;
  localparam int MAX_CYCLES = 4 * PROG_WORDS;

  logic             clock;
  logic             reset;
  logic             load_enable;
  rv_pkg::word_t    load_address;
  rv_pkg::word_t    load_data;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    inst;
  rv_pkg::word_t    bus_address;
  rv_pkg::word_t    bus_write_data;
  rv_pkg::word_t    bus_read_data;
  rv_pkg::byte_en_t bus_byte_enable;
  logic             bus_read_enable;
  logic             bus_write_enable;
  int               seed;
  int               cycles;

  `include "rv_model.svh"

  toplevel #(
    .TEXT_ADDR_BITS(TEXT_BITS),
    .DATA_ADDR_BITS(DATA_BITS)
  ) UUT (
    .i_clock(clock),
    .i_reset(reset),
    .i_load_enable(load_enable),
    .i_load_address(load_address),
    .i_load_data(load_data),
    .o_pc(pc),
    .o_inst(inst),
    .o_bus_address(bus_address),
    .o_bus_write_data(bus_write_data),
    .o_bus_read_data(bus_read_data),
    .o_bus_byte_enable(bus_byte_enable),
    .o_bus_read_enable(bus_read_enable),
    .o_bus_write_enable(bus_write_enable)
  );

  // 20 ns clock
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_value(input string name, input rv_pkg::word_t actual,
                             input rv_pkg::word_t expected);
    if (actual !== expected) begin
      $display("ERR %0t %s actual %h expected %h", $time, name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  initial begin
    seed         = 32'h48748608;
    reset        = 1'b1;
    load_enable  = 1'b0;
    load_address = '0;
    load_data    = '0;
    cycles       = 0;
    build_program();
    reset_model();

    // --------------------------------------------------
    // Program load while the core is held in reset
    // --------------------------------------------------
    for (int i = 0; i < PROG_WORDS; i++) begin
      @(posedge clock);
      #2;
      load_enable  = 1'b1;
      load_address = i;
      load_data    = prog[i];
    end
    @(posedge clock);
    #2;
    load_enable = 1'b0;

    // Five more reset cycles, quiet bus at the end
    repeat (4) @(posedge clock);
    @(negedge clock);
    check_value("o_pc", pc, 32'd0);
    check_value("o_bus_read_enable", 32'(bus_read_enable), 32'd0);
    check_value("o_bus_write_enable", 32'(bus_write_enable), 32'd0);
    @(posedge clock);
    #2;
    reset = 1'b0;

    // --------------------------------------------------
    // One instruction per cycle up to the self loop
    // --------------------------------------------------
    while (!at_loop) begin
      @(negedge clock);
      check_value("o_pc", pc, m_pc);
      check_value("o_inst", inst, prog[m_pc[TEXT_BITS+1:2]]);
      execute_model();
      check_value("o_bus_write_enable", 32'(bus_write_enable), 32'(exp_we));
      check_value("o_bus_read_enable", 32'(bus_read_enable), 32'(exp_re));
      if (exp_we) begin
        check_value("o_bus_address", bus_address, exp_addr);
        check_value("o_bus_byte_enable", 32'(bus_byte_enable), 32'(exp_be));
        check_value("o_bus_write_data", bus_write_data, exp_wdata);
      end
      if (exp_re) begin
        check_value("o_bus_address", bus_address, exp_addr);
        check_value("o_bus_read_data", bus_read_data, exp_rdata);
      end
      cycles++;
      if (cycles > MAX_CYCLES) begin
        $display("Timeout: program never reached its final self loop");
        $display("*** FAILED ***");
        $fatal(1, "Timeout after %0d cycles", cycles);
      end
    end

    // PC stays on the self loop
    repeat (4) begin
      @(negedge clock);
      check_value("o_pc", pc, m_pc);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- toplevel.f
+incdir+test
common/rv_pkg.sv
common/data_bus_if.sv
core/instr_decoder.sv
core/alu_execute.sv
core/result_select.sv
core/riscv_core.sv
src/text_memory.sv
src/data_memory.sv
src/toplevel.sv
test/tb_toplevel.sv
